// ==== logic/friscv_pkg.sv ====
// Shared widths, RV32I opcode and funct codes, status bit positions

`default_nettype none

package friscv_pkg;

    //////////////////////////////
    // Architecture widths
    //////////////////////////////

    localparam int XLEN = 32;
    localparam int ILEN = 32;
    localparam int NB_REGS = 32;
    localparam int REG_ADDR_W = 5;

    // AXI4-lite read channel field widths
    localparam int PROT_W = 3;
    localparam int RESP_W = 2;

    // Core status bus
    localparam int STATUS_W = 8;

    //////////////////////////////
    // Major opcodes accepted
    //////////////////////////////

    localparam logic [6:0] OPCODE_OP = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI = 7'b0110111;

    // Funct3 encodings shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Funct7 values, ALT selects SUB and SRA/SRAI
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;

    //////////////////////////////
    // Status bit positions
    //////////////////////////////

    localparam int STATUS_ILLEGAL = 0;
    localparam int STATUS_FETCH_ERR = 1;

endpackage

`default_nettype wire

// ==== logic/friscv_control.sv ====
// Instruction fetch sequencer on the AXI4-lite read channel
// Pushes every returned word into the instruction queue

`timescale 1ns/10ps
`default_nettype none

module friscv_control #(
    parameter logic [friscv_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
    input  wire                           aclk,
    input  wire                           rst_n,
    // Instruction memory read channel
    output logic                          imem_arvalid,
    input  wire                           imem_arready,
    output logic [friscv_pkg::XLEN  -1:0] imem_araddr,
    output logic [friscv_pkg::PROT_W-1:0] imem_arprot,
    input  wire                           imem_rvalid,
    output logic                          imem_rready,
    input  wire  [friscv_pkg::RESP_W-1:0] imem_rresp,
    input  wire  [friscv_pkg::ILEN  -1:0] imem_rdata,
    // Instruction queue write side
    output logic                          push,
    output logic [friscv_pkg::ILEN  -1:0] push_data,
    input  wire                           full,
    output logic                          fetch_err
);

    // Unprivileged, secure, instruction access
    localparam logic [friscv_pkg::PROT_W-1:0] INST_PROT = 3'b100;

    typedef enum logic {
        ST_REQ,
        ST_WAIT
    } fetch_state_t;

    fetch_state_t state;
    logic [friscv_pkg::XLEN-1:0] pc;
    logic ar_done;

    //////////////////////////////
    // Fetch FSM
    //////////////////////////////

    assign ar_done = imem_arvalid && imem_arready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= ST_REQ;
            pc <= BOOT_ADDR;
            imem_arvalid <= 1'b0;
        end else begin
            case (state)
                ST_REQ: begin
                    if (ar_done) begin
                        imem_arvalid <= 1'b0;
                        state <= ST_WAIT;
                    end else begin
                        imem_arvalid <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    // Next request goes out right after the data beat
                    if (push) begin
                        pc <= pc + friscv_pkg::XLEN'(4);
                        imem_arvalid <= 1'b1;
                        state <= ST_REQ;
                    end
                end
                default: state <= ST_REQ;
            endcase
        end
    end

    assign imem_araddr = pc;
    assign imem_arprot = INST_PROT;

    // Data beat is only taken when the queue has room
    assign imem_rready = (state == ST_WAIT) && !full;

    assign push = imem_rvalid && imem_rready;
    assign push_data = imem_rdata;

    // Error response is flagged but the word still goes to the queue
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            fetch_err <= 1'b0;
        end else if (push && (imem_rresp != '0)) begin
            fetch_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/friscv_inst_queue.sv ====
// Circular FIFO of fetched instruction words

`timescale 1ns/10ps
`default_nettype none

module friscv_inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                         aclk,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire  [friscv_pkg::ILEN-1:0] push_data,
    output logic                        full,
    output logic                        proc_valid,
    output logic [friscv_pkg::ILEN-1:0] proc_instbus,
    input  wire                         proc_ready
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [friscv_pkg::ILEN-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic wr_en;
    logic rd_en;

    assign wr_en = push && !full;
    assign rd_en = proc_valid && proc_ready;

    // Storage
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign proc_valid = (count != '0);
    assign proc_instbus = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/friscv_processing.sv ====
// Decode and integer ALU for OP, OP-IMM and LUI
// One instruction per cycle, results written back through the register port

`timescale 1ns/10ps
`default_nettype none

module friscv_processing (
    input  wire                               aclk,
    input  wire                               rst_n,
    input  wire                               proc_valid,
    input  wire  [friscv_pkg::ILEN      -1:0] proc_instbus,
    output logic                              proc_ready,
    output logic [friscv_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [friscv_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  wire  [friscv_pkg::XLEN      -1:0] rs1_val,
    input  wire  [friscv_pkg::XLEN      -1:0] rs2_val,
    output logic                              rd_wr,
    output logic [friscv_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [friscv_pkg::XLEN      -1:0] rd_val,
    output logic                              illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic is_op;
    logic is_opimm;
    logic is_lui;
    logic legal;
    logic pop;
    logic [friscv_pkg::XLEN-1:0] imm_i;
    logic [friscv_pkg::XLEN-1:0] imm_u;
    logic [friscv_pkg::XLEN-1:0] op_b;
    logic [4:0] shamt;
    logic [friscv_pkg::XLEN-1:0] alu_res;

    //////////////////////////////
    // Decode
    //////////////////////////////

    assign opcode = proc_instbus[6:0];
    assign rd_addr = proc_instbus[11:7];
    assign funct3 = proc_instbus[14:12];
    assign rs1_addr = proc_instbus[19:15];
    assign rs2_addr = proc_instbus[24:20];
    assign funct7 = proc_instbus[31:25];

    assign is_op = (opcode == friscv_pkg::OPCODE_OP);
    assign is_opimm = (opcode == friscv_pkg::OPCODE_OPIMM);
    assign is_lui = (opcode == friscv_pkg::OPCODE_LUI);

    assign imm_i = {{20{proc_instbus[31]}}, proc_instbus[31:20]};
    assign imm_u = {proc_instbus[31:12], 12'b0};

    // Funct7 must be a known encoding for the selected operation
    always_comb begin
        legal = 1'b0;
        if (is_lui) begin
            legal = 1'b1;
        end else if (is_op) begin
            legal = (funct7 == friscv_pkg::F7_BASE) ||
                    ((funct7 == friscv_pkg::F7_ALT) &&
                     (funct3 == friscv_pkg::F3_ADD || funct3 == friscv_pkg::F3_SR));
        end else if (is_opimm) begin
            if (funct3 == friscv_pkg::F3_SLL) begin
                legal = (funct7 == friscv_pkg::F7_BASE);
            end else if (funct3 == friscv_pkg::F3_SR) begin
                legal = (funct7 == friscv_pkg::F7_BASE) || (funct7 == friscv_pkg::F7_ALT);
            end else begin
                legal = 1'b1;
            end
        end
    end

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign op_b = is_opimm ? imm_i : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        alu_res = '0;
        case (funct3)
            friscv_pkg::F3_ADD: begin
                // SUB exists only in the register-register form
                alu_res = (is_op && funct7[5]) ? rs1_val - op_b : rs1_val + op_b;
            end
            friscv_pkg::F3_SLL: alu_res = rs1_val << shamt;
            friscv_pkg::F3_SLT: alu_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
            friscv_pkg::F3_SLTU: alu_res = {31'b0, rs1_val < op_b};
            friscv_pkg::F3_XOR: alu_res = rs1_val ^ op_b;
            friscv_pkg::F3_SR: begin
                alu_res = funct7[5] ? $unsigned($signed(rs1_val) >>> shamt) : rs1_val >> shamt;
            end
            friscv_pkg::F3_OR: alu_res = rs1_val | op_b;
            friscv_pkg::F3_AND: alu_res = rs1_val & op_b;
            default: alu_res = '0;
        endcase
    end

    assign rd_val = is_lui ? imm_u : alu_res;

    //////////////////////////////
    // Handshake and write-back
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            proc_ready <= 1'b0;
            illegal <= 1'b0;
        end else begin
            proc_ready <= 1'b1;
            if (pop && !legal) begin
                illegal <= 1'b1;
            end
        end
    end

    assign pop = proc_valid && proc_ready;
    assign rd_wr = pop && legal;

endmodule

`default_nettype wire

// ==== logic/friscv_registers.sv ====
// ISA integer register file, x0 hardwired to zero, full debug export

`timescale 1ns/10ps
`default_nettype none

module friscv_registers (
    input  wire                                             aclk,
    input  wire                                             rst_n,
    input  wire  [friscv_pkg::REG_ADDR_W                -1:0] rs1_addr,
    input  wire  [friscv_pkg::REG_ADDR_W                -1:0] rs2_addr,
    output logic [friscv_pkg::XLEN                      -1:0] rs1_val,
    output logic [friscv_pkg::XLEN                      -1:0] rs2_val,
    input  wire                                             rd_wr,
    input  wire  [friscv_pkg::REG_ADDR_W                -1:0] rd_addr,
    input  wire  [friscv_pkg::XLEN                      -1:0] rd_val,
    output logic [friscv_pkg::NB_REGS*friscv_pkg::XLEN  -1:0] dbg_regs
);

    localparam int XLEN = friscv_pkg::XLEN;
    localparam int NB_REGS = friscv_pkg::NB_REGS;

    // x1 to x31, x0 has no storage
    logic [XLEN-1:0] regs [1:NB_REGS-1];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 1; i < NB_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_val;
        end
    end

    // Asynchronous read ports
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    //////////////////////////////
    // Debug export
    //////////////////////////////

    assign dbg_regs[0 +: XLEN] = '0;

    generate
        for (genvar i = 1; i < NB_REGS; i++) begin : gen_dbg
            assign dbg_regs[i*XLEN +: XLEN] = regs[i];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== logic/friscv_core.sv ====
// RV32I core top level
// Fetch control, instruction queue, processing unit and integer registers

`timescale 1ns/10ps
`default_nettype none

module friscv_core #(
    parameter logic [friscv_pkg::XLEN-1:0] BOOT_ADDR = '0,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                                              aclk,
    input  wire                                              rst_n,
    // Instruction memory interface
    output logic                                             imem_arvalid,
    input  wire                                              imem_arready,
    output logic [friscv_pkg::XLEN                     -1:0] imem_araddr,
    output logic [friscv_pkg::PROT_W                   -1:0] imem_arprot,
    input  wire                                              imem_rvalid,
    output logic                                             imem_rready,
    input  wire  [friscv_pkg::RESP_W                   -1:0] imem_rresp,
    input  wire  [friscv_pkg::ILEN                     -1:0] imem_rdata,
    // Core debug
    output logic [friscv_pkg::STATUS_W                 -1:0] status,
    output logic [friscv_pkg::NB_REGS*friscv_pkg::XLEN -1:0] dbg_regs
);

    logic push;
    logic [friscv_pkg::ILEN-1:0] push_data;
    logic full;
    logic fetch_err;

    logic proc_valid;
    logic [friscv_pkg::ILEN-1:0] proc_instbus;
    logic proc_ready;
    logic illegal;

    logic [friscv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [friscv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [friscv_pkg::XLEN-1:0] rs1_val;
    logic [friscv_pkg::XLEN-1:0] rs2_val;
    logic rd_wr;
    logic [friscv_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [friscv_pkg::XLEN-1:0] rd_val;

    //////////////////////////////
    // Status bus
    //////////////////////////////

    always_comb begin
        status = '0;
        status[friscv_pkg::STATUS_ILLEGAL] = illegal;
        status[friscv_pkg::STATUS_FETCH_ERR] = fetch_err;
    end

    //////////////////////////////
    // Fetch and buffering
    //////////////////////////////

    friscv_control #(
        .BOOT_ADDR (BOOT_ADDR)
    ) control (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_arprot  (imem_arprot),
        .imem_rvalid  (imem_rvalid),
        .imem_rready  (imem_rready),
        .imem_rresp   (imem_rresp),
        .imem_rdata   (imem_rdata),
        .push         (push),
        .push_data    (push_data),
        .full         (full),
        .fetch_err    (fetch_err)
    );

    friscv_inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) inst_queue (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .push         (push),
        .push_data    (push_data),
        .full         (full),
        .proc_valid   (proc_valid),
        .proc_instbus (proc_instbus),
        .proc_ready   (proc_ready)
    );

    //////////////////////////////
    // Execution
    //////////////////////////////

    friscv_processing processing (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .proc_valid   (proc_valid),
        .proc_instbus (proc_instbus),
        .proc_ready   (proc_ready),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .rd_wr        (rd_wr),
        .rd_addr      (rd_addr),
        .rd_val       (rd_val),
        .illegal      (illegal)
    );

    friscv_registers isa_registers (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val),
        .dbg_regs (dbg_regs)
    );

endmodule

`default_nettype wire

// ==== tests/friscv_checker.sv ====
// Result checker for the core testbench
// Holds the expected register list and compares it with the debug bus

`timescale 1ns/10ps
`default_nettype none

module friscv_checker (
    input  wire                                              aclk,
    input  wire                                              rst_n,
    input  wire                                              imem_arvalid,
    input  wire  [friscv_pkg::PROT_W                   -1:0] imem_arprot,
    input  wire  [friscv_pkg::NB_REGS*friscv_pkg::XLEN -1:0] dbg_regs,
    input  wire  [friscv_pkg::STATUS_W                 -1:0] status,
    output logic                                             done,
    output int                                               pass_count,
    output int                                               fail_count
);

    localparam int XLEN = friscv_pkg::XLEN;
    localparam int NB_REGS = friscv_pkg::NB_REGS;
    localparam int STATUS_W = friscv_pkg::STATUS_W;
    localparam int TEST_TIMEOUT = 2000;
    localparam int RESET_TIMEOUT = 100;
    // AXI ARPROT bit 2 marks an instruction access
    localparam int PROT_INST_BIT = 2;

    string test_name [$];
    int test_reg [$];
    logic [XLEN-1:0] test_exp [$];
    logic test_has_status [$];
    logic [STATUS_W-1:0] test_status [$];

    int prot_checked = 0;
    int prot_errors = 0;

    task automatic add_test(input string name, input int reg_idx,
                            input logic [XLEN-1:0] expected, input logic has_status,
                            input logic [STATUS_W-1:0] exp_status);
        test_name.push_back(name);
        test_reg.push_back(reg_idx);
        test_exp.push_back(expected);
        test_has_status.push_back(has_status);
        test_status.push_back(exp_status);
    endtask

    // Waits for the register to reach its value, then checks status
    task automatic run_test(input int k);
        int cycles;
        logic matched;
        logic [XLEN-1:0] actual;
        cycles = 0;
        matched = 1'b0;
        actual = '0;
        if (test_reg[k] < 0 || test_reg[k] >= NB_REGS) begin
            $display("Test %s names register %0d, which does not exist", test_name[k],
                     test_reg[k]);
            fail_count++;
            return;
        end
        while (!matched && cycles < TEST_TIMEOUT) begin
            @(negedge aclk);
            actual = dbg_regs[test_reg[k]*XLEN +: XLEN];
            matched = (actual === test_exp[k]);
            cycles++;
        end
        if (!matched) begin
            $display("ERR %s x%0d expected %08h actual %08h", test_name[k], test_reg[k],
                     test_exp[k], actual);
            fail_count++;
        end else if (test_has_status[k] && status !== test_status[k]) begin
            $display("ERR %s status expected %02h actual %02h", test_name[k],
                     test_status[k], status);
            fail_count++;
        end else begin
            $display("PASS %s x%0d = %08h", test_name[k], test_reg[k], actual);
            pass_count++;
        end
    endtask

    // Every read request must be flagged as an instruction access
    always @(negedge aclk) begin
        if (rst_n === 1'b1 && imem_arvalid === 1'b1) begin
            prot_checked++;
            if (imem_arprot[PROT_INST_BIT] !== 1'b1) begin
                if (prot_errors == 0) begin
                    $display("ERR arprot_inst expected 1 actual %0b",
                             imem_arprot[PROT_INST_BIT]);
                end
                prot_errors++;
            end
        end
    end

    initial begin
        int cycles;
        done = 1'b0;
        pass_count = 0;
        fail_count = 0;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge aclk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released, so no test could run");
            fail_count++;
        end else begin
            for (int k = 0; k < test_name.size(); k++) begin
                run_test(k);
            end
            if (prot_checked == 0) begin
                $display("No instruction read request was seen, so arprot was never checked");
                fail_count++;
            end else if (prot_errors != 0) begin
                $display("ERR arprot_inst expected 1 actual 0 on %0d of %0d requests",
                         prot_errors, prot_checked);
                fail_count++;
            end else begin
                $display("PASS arprot_inst on %0d requests", prot_checked);
                pass_count++;
            end
        end
        $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
        done = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/friscv_core_tb.sv ====
// Testbench top for the RV32I core
// Clock, reset, program loader and AXI4-lite instruction memory model

`timescale 1ns/10ps
`default_nettype none

module friscv_core_tb;

    localparam int XLEN = friscv_pkg::XLEN;
    localparam int NB_REGS = friscv_pkg::NB_REGS;
    localparam int STATUS_W = friscv_pkg::STATUS_W;
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    localparam int DONE_TIMEOUT = 200000;

    logic aclk;
    logic rst_n;
    logic imem_arvalid;
    logic imem_arready = 1'b0;
    logic [XLEN-1:0] imem_araddr;
    logic [friscv_pkg::PROT_W-1:0] imem_arprot;
    logic imem_rvalid = 1'b0;
    logic imem_rready;
    logic [friscv_pkg::RESP_W-1:0] imem_rresp = '0;
    logic [friscv_pkg::ILEN-1:0] imem_rdata = '0;
    logic [STATUS_W-1:0] status;
    logic [NB_REGS*XLEN-1:0] dbg_regs;

    logic checks_done;
    int pass_count;
    int fail_count;
    logic load_ok;

    // Program image and memory model state
    logic [31:0] program_q [$];
    logic [31:0] rng_state = 32'd24;
    logic [XLEN-1:0] read_addr;
    int ar_stall;
    int r_stall;
    logic r_pending;
    logic ar_fire;
    logic r_fire;

    //////////////////////////////
    // DUT and checker
    //////////////////////////////

    friscv_core #(
        .BOOT_ADDR   (32'h0000_0000),
        .QUEUE_DEPTH (4)
    ) i_dut (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_arprot  (imem_arprot),
        .imem_rvalid  (imem_rvalid),
        .imem_rready  (imem_rready),
        .imem_rresp   (imem_rresp),
        .imem_rdata   (imem_rdata),
        .status       (status),
        .dbg_regs     (dbg_regs)
    );

    friscv_checker i_checker (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_arvalid (imem_arvalid),
        .imem_arprot  (imem_arprot),
        .dbg_regs     (dbg_regs),
        .status       (status),
        .done         (checks_done),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    always #2 aclk = ~aclk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Stall of 0 to 3 cycles
    task automatic draw_stall(output int stall);
        rng_state = xorshift32(rng_state);
        stall = int'(rng_state[1:0]);
    endtask

    function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < program_q.size()) begin
            return program_q[idx];
        end
        return NOP_WORD;
    endfunction

    // I lines fill the program, T lines go to the checker
    task automatic load_program(output logic ok);
        int fd;
        int n;
        string line;
        string tag;
        string name;
        int reg_idx;
        logic [31:0] value;
        logic [STATUS_W-1:0] exp_status;
        ok = 1'b0;
        fd = $fopen("tests/program_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", tag);
            if (n >= 1 && tag == "I") begin
                n = $sscanf(line, "%s %h", tag, value);
                if (n == 2) begin
                    program_q.push_back(value);
                end
            end else if (n >= 1 && tag == "T") begin
                exp_status = '0;
                n = $sscanf(line, "%s %s %d %h %h", tag, name, reg_idx, value, exp_status);
                if (n >= 4) begin
                    i_checker.add_test(name, reg_idx, value, n == 5, exp_status);
                end
            end
        end
        $fclose(fd);
        ok = (program_q.size() > 0);
    endtask

    //////////////////////////////
    // Instruction memory model
    //////////////////////////////

    always @(negedge aclk) begin
        if (!rst_n) begin
            imem_arready = 1'b0;
            imem_rvalid = 1'b0;
            imem_rdata = '0;
            ar_stall = 0;
            r_stall = 0;
            r_pending = 1'b0;
            ar_fire = 1'b0;
            r_fire = 1'b0;
        end else begin
            // Handshakes that completed on the last rising edge
            if (ar_fire) begin
                imem_arready = 1'b0;
                r_pending = 1'b1;
                draw_stall(r_stall);
            end
            if (r_fire) begin
                imem_rvalid = 1'b0;
                draw_stall(ar_stall);
            end
            // Address accepted after a random wait
            if (imem_arvalid && !imem_arready) begin
                if (ar_stall == 0) begin
                    imem_arready = 1'b1;
                    read_addr = imem_araddr;
                end else begin
                    ar_stall--;
                end
            end
            if (r_pending) begin
                if (r_stall == 0) begin
                    imem_rvalid = 1'b1;
                    imem_rdata = fetch_word(read_addr);
                    r_pending = 1'b0;
                end else begin
                    r_stall--;
                end
            end
            // rready only moves on rising edges, so this predicts the next one
            ar_fire = imem_arvalid && imem_arready;
            r_fire = imem_rvalid && imem_rready;
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int cycles;
        aclk = 1'b0;
        rst_n = 1'b0;
        cycles = 0;
        load_program(load_ok);
        if (!load_ok) begin
            $display("Could not read any instruction from tests/program_input.txt");
            $display("Simulation FAILED");
        end else begin
            repeat (2) @(negedge aclk);
            rst_n = 1'b1;
            while (!checks_done && cycles < DONE_TIMEOUT) begin
                @(negedge aclk);
                cycles++;
            end
            if (!checks_done) begin
                $display("Timed out waiting for the checker to finish its test list");
                $display("Simulation FAILED");
            end else if (fail_count == 0 && pass_count > 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/program_input.txt ====
# I <instruction word, hex>  then an optional note
# T <test name> <register index, decimal> <expected value, hex> [<expected status, hex>]
I 06400093  addi x1, x0, 100
I ed408113  addi x2, x1, -300
I f3912193  slti x3, x2, -199
I fff0b213  sltiu x4, x1, -1
I fff0c293  xori x5, x1, -1
I 7030e313  ori x6, x1, 0x703
I 0f017393  andi x7, x2, 0x0f0
T addi 1 00000064
T addi_neg 2 ffffff38
T slti 3 00000001
T sltiu 4 00000001
T xori 5 ffffff9b
T ori 6 00000767
T andi 7 00000030
I 00608433  add x8, x1, x6
I 405404b3  sub x9, x8, x5
I 00449533  sll x10, x9, x4
I 403155b3  sra x11, x2, x3
I 0045d633  srl x12, x11, x4
I 00c5a6b3  slt x13, x11, x12
I 00b63733  sltu x14, x12, x11
I 00a677b3  and x15, x12, x10
T add 8 000007cb
T sub 9 00000830
T sll 10 00001060
T sra 11 ffffff9c
T srl 12 7fffffce
T slt 13 00000001
T sltu 14 00000001
T and 15 00001040
I deadc837  lui x16, 0xdeadc
I eef80813  addi x16, x16, -0x111
I 123458b7  lui x17, 0x12345
I 67888893  addi x17, x17, 0x678
I 80000937  lui x18, 0x80000
T lui_addi_neg 16 deadbeef
T lui_addi_pos 17 12345678
T lui 18 80000000
I 05500013  addi x0, x0, 0x55
I 00608033  add x0, x1, x6
I fffff037  lui x0, 0xfffff
I 00700993  addi x19, x0, 7
T x0_read 19 00000007
T x0_zero 0 00000000
T x0_keep_x6 6 00000767
I 00102623  sw x1, 12(x0), rd field selects x12
I 02a00a13  addi x20, x0, 42
T illegal_next 20 0000002a 01
T illegal_no_write 12 7fffffce 01
I 00100f13  addi x30, x0, 1
I 001f1f13  slli x30, x30, 1
I 003f0f13  addi x30, x30, 3
I 001f1f13  slli x30, x30, 1
I 005f0f13  addi x30, x30, 5
I 0f0f4f13  xori x30, x30, 0x0f0
I 002f1f13  slli x30, x30, 2
I ff9f0f13  addi x30, x30, -7
I 01ef0f33  add x30, x30, x30
I 155f4f13  xori x30, x30, 0x155
I 003f1f13  slli x30, x30, 3
I 009f0f13  addi x30, x30, 9
T accumulate 30 00003601 01

// ==== files.f ====
logic/friscv_pkg.sv
logic/friscv_control.sv
logic/friscv_inst_queue.sv
logic/friscv_processing.sv
logic/friscv_registers.sv
logic/friscv_core.sv
tests/friscv_checker.sv
tests/friscv_core_tb.sv

// ==== Makefile ====
TOP := friscv_core_tb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

build:
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
		-f files.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -Wall \
		-f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
